// ==== Bender.yml ====
package:
  name: harness_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/dmi_pkg.sv
      - hw/mem_pkg.sv
      - hw/dmi_source_mux.sv
      - hw/dm_regs.sv
      - hw/mem_router.sv
      - hw/boot_rom.sv
      - hw/sram_be.sv
      - hw/harness_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/harness_tb.sv

// ==== dv/harness_tb.sv ====
`timescale 1ns/100ps
`include "harness_config.svh"

module harness_tb;

  localparam logic [1:0] OpNop   = dmi_pkg::DMI_NOP;
  localparam logic [1:0] OpRead  = dmi_pkg::DMI_READ;
  localparam logic [1:0] OpWrite = dmi_pkg::DMI_WRITE;
  localparam int unsigned Timeout = 50;
  localparam int unsigned NumStim = 23;
  localparam logic [31:0] RamEnd = `HC_RAM_BASE + `HC_RAM_WORDS * `HC_BE_W;

  typedef struct packed {
    logic        is_dmi;
    logic        sel;
    logic [31:0] addr;
    logic [1:0]  op;
    logic [3:0]  be;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic        exp_err;
    logic        use_model;
  } stim_t;

  logic               clk_i;
  logic               ndmreset_n;
  logic               dbg_sel_i;
  logic               a_req_valid_i;
  logic               b_req_valid_i;
  dmi_pkg::dmi_req_t  a_req_i;
  dmi_pkg::dmi_req_t  b_req_i;
  logic               a_resp_ready_i;
  logic               b_resp_ready_i;
  logic               a_req_ready_o;
  logic               b_req_ready_o;
  logic               a_resp_valid_o;
  logic               b_resp_valid_o;
  dmi_pkg::dmi_resp_t resp_o;
  logic               mem_req_valid_i;
  mem_pkg::mem_req_t  mem_req_i;
  logic               mem_rsp_valid_o;
  mem_pkg::mem_rsp_t  mem_rsp_o;
  logic               debug_req_o;

  logic [7:0]  lfsr_q;
  logic [7:0]  ram_model [`HC_RAM_WORDS * `HC_BE_W];
  logic        pend;
  logic        pend_read;
  logic        pend_err;
  logic [31:0] pend_data;
  logic        dbg_at_accept;
  logic        exp_expired;
  int unsigned cycles_q;

  // Memory entries run back to back, DMI entries through the mux
  stim_t stim [NumStim] = '{
    '{1'b0, 1'b0, 32'h0001_0000, OpRead,  4'hF, 32'h0, 32'hB007_0000, 1'b0, 1'b0},
    '{1'b0, 1'b0, 32'h0001_000C, OpRead,  4'hF, 32'h0, 32'hB007_0003, 1'b0, 1'b0},
    '{1'b0, 1'b0, 32'h0001_00FC, OpRead,  4'hF, 32'h0, 32'hB007_003F, 1'b0, 1'b0},
    '{1'b0, 1'b0, 32'h0001_000C, OpWrite, 4'hF, 32'hDEAD_BEEF, 32'h0, 1'b1, 1'b0},
    '{1'b0, 1'b0, 32'h0001_000C, OpRead,  4'hF, 32'h0, 32'hB007_0003, 1'b0, 1'b0},
    '{1'b0, 1'b0, 32'h8000_0000, OpWrite, 4'hF, 32'h1122_3344, 32'h0, 1'b0, 1'b0},
    '{1'b0, 1'b0, 32'h8000_0000, OpWrite, 4'h5, 32'hAABB_CCDD, 32'h0, 1'b0, 1'b0},
    '{1'b0, 1'b0, 32'h8000_0010, OpWrite, 4'hC, 32'h5566_7788, 32'h0, 1'b0, 1'b0},
    '{1'b0, 1'b0, 32'h8000_0000, OpRead,  4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
    '{1'b0, 1'b0, 32'h8000_0010, OpRead,  4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
    '{1'b0, 1'b0, 32'h8000_03FC, OpRead,  4'hF, 32'h0, 32'h0, 1'b0, 1'b1},
    '{1'b0, 1'b0, 32'h4000_0000, OpRead,  4'hF, 32'h0, 32'h0, 1'b1, 1'b0},
    '{1'b0, 1'b0, 32'h8000_0400, OpWrite, 4'hF, 32'h1234_0000, 32'h0, 1'b1, 1'b0},
    '{1'b1, 1'b0, 32'(`HC_DMI_DATA0), OpWrite, 4'h0, 32'h1234_5678, 32'h0, 1'b0, 1'b0},
    '{1'b1, 1'b0, 32'(`HC_DMI_DATA0), OpRead, 4'h0, 32'h0, 32'h1234_5678, 1'b0, 1'b0},
    '{1'b1, 1'b1, 32'(`HC_DMI_DATA0), OpRead, 4'h0, 32'h0, 32'h1234_5678, 1'b0, 1'b0},
    '{1'b1, 1'b1, 32'h0000_0020, OpRead, 4'h0, 32'h0, 32'h0, 1'b1, 1'b0},
    '{1'b1, 1'b1, 32'(`HC_DMI_DMSTATUS), OpWrite, 4'h0, 32'hFFFF_FFFF, 32'h0, 1'b0, 1'b0},
    '{1'b1, 1'b1, 32'(`HC_DMI_DMSTATUS), OpRead, 4'h0, 32'h0, 32'h1, 1'b0, 1'b0},
    '{1'b1, 1'b0, 32'(`HC_DMI_DATA0), OpNop, 4'h0, 32'h0, 32'h0, 1'b1, 1'b0},
    '{1'b1, 1'b0, 32'(`HC_DMI_DMCONTROL), OpRead, 4'h0, 32'h0, 32'h0, 1'b0, 1'b0},
    '{1'b1, 1'b0, 32'(`HC_DMI_DATA0), OpWrite, 4'h0, 32'hCAFE_F00D, 32'h0, 1'b0, 1'b0},
    '{1'b1, 1'b1, 32'(`HC_DMI_DATA0), OpRead, 4'h0, 32'h0, 32'hCAFE_F00D, 1'b0, 1'b0}
  };

  harness_top dut_i (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .dbg_sel_i       ( dbg_sel_i       ),
    .a_req_valid_i   ( a_req_valid_i   ),
    .b_req_valid_i   ( b_req_valid_i   ),
    .a_req_i         ( a_req_i         ),
    .b_req_i         ( b_req_i         ),
    .a_resp_ready_i  ( a_resp_ready_i  ),
    .b_resp_ready_i  ( b_resp_ready_i  ),
    .a_req_ready_o   ( a_req_ready_o   ),
    .b_req_ready_o   ( b_req_ready_o   ),
    .a_resp_valid_o  ( a_resp_valid_o  ),
    .b_resp_valid_o  ( b_resp_valid_o  ),
    .resp_o          ( resp_o          ),
    .mem_req_valid_i ( mem_req_valid_i ),
    .mem_req_i       ( mem_req_i       ),
    .mem_rsp_valid_o ( mem_rsp_valid_o ),
    .mem_rsp_o       ( mem_rsp_o       ),
    .debug_req_o     ( debug_req_o     )
  );

  always #5 clk_i = ~clk_i;

  // Clock edges since reset release
  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cycles_q <= 0;
    end else begin
      cycles_q <= cycles_q + 1;
    end
  end

  // ------------------------------
  // Error reporting
  // ------------------------------
  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  task automatic pick_stall(output int unsigned n);
    n = 0;
    for (int b = 0; b < 3; b++) begin
      n = n * 2 + 32'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // ------------------------------
  // RAM byte model
  // ------------------------------
  function automatic logic in_ram(input logic [31:0] a);
    return (a >= `HC_RAM_BASE) && (a < RamEnd);
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] a);
    int unsigned w;
    w = (a - `HC_RAM_BASE) / 4;
    return {ram_model[4*w+3], ram_model[4*w+2], ram_model[4*w+1], ram_model[4*w]};
  endfunction

  task automatic model_write(input logic [31:0] a, input logic [3:0] be,
                             input logic [31:0] d);
    int unsigned w;
    w = (a - `HC_RAM_BASE) / 4;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        ram_model[4*w+b] = d[8*b +: 8];
      end
    end
  endtask

  // Response of the previous strobe is due at this falling edge
  task automatic check_mem_rsp();
    if (pend) begin
      assert (mem_rsp_valid_o) else report_mismatch("no memory response after strobe");
      assert (mem_rsp_o.err == pend_err)
        else report_mismatch($sformatf("memory err %b, expected %b", mem_rsp_o.err, pend_err));
      if (pend_read) begin
        assert (mem_rsp_o.rdata == pend_data)
          else report_mismatch($sformatf("memory rdata %h, expected %h",
                                         mem_rsp_o.rdata, pend_data));
      end
    end else begin
      assert (!mem_rsp_valid_o) else report_mismatch("memory response without a strobe");
    end
    pend = 1'b0;
  endtask

  task automatic mem_issue(input stim_t s);
    mem_pkg::mem_req_t req;
    @(negedge clk_i);
    check_mem_rsp();
    req.addr  = s.addr;
    req.we    = (s.op == OpWrite);
    req.be    = s.be;
    req.wdata = s.data;
    pend      = 1'b1;
    pend_read = !req.we;
    pend_err  = s.exp_err;
    pend_data = s.use_model ? model_word(s.addr) : s.exp_data;
    if (req.we && in_ram(s.addr)) begin
      model_write(s.addr, s.be, s.data);
    end
    mem_req_valid_i = 1'b1;
    mem_req_i       = req;
  endtask

  task automatic mem_flush();
    @(negedge clk_i);
    check_mem_rsp();
    mem_req_valid_i = 1'b0;
  endtask

  // ------------------------------
  // Debug link helpers
  // ------------------------------
  function automatic logic sel_resp_valid();
    return dbg_sel_i ? b_resp_valid_o : a_resp_valid_o;
  endfunction

  function automatic logic sel_req_ready();
    return dbg_sel_i ? b_req_ready_o : a_req_ready_o;
  endfunction

  task automatic check_other_quiet();
    if (dbg_sel_i) begin
      assert (!a_req_ready_o && !a_resp_valid_o)
        else report_mismatch("source A sees handshake while B is selected");
    end else begin
      assert (!b_req_ready_o && !b_resp_valid_o)
        else report_mismatch("source B sees handshake while A is selected");
    end
  endtask

  task automatic drive_dmi(input logic sel, input logic valid, input dmi_pkg::dmi_req_t req);
    if (sel) begin
      b_req_valid_i = valid;
      b_req_i       = req;
    end else begin
      a_req_valid_i = valid;
      a_req_i       = req;
    end
  endtask

  task automatic set_resp_ready(input logic sel, input logic rdy);
    if (sel) begin
      b_resp_ready_i = rdy;
    end else begin
      a_resp_ready_i = rdy;
    end
  endtask

  task automatic dmi_xfer(input logic sel, input logic [6:0] addr, input logic [1:0] op,
                          input logic [31:0] data, output dmi_pkg::dmi_resp_t rsp);
    dmi_pkg::dmi_req_t req;
    int unsigned       wait_cnt;
    int unsigned       stall;
    req.addr = addr;
    req.op   = dmi_pkg::dmi_op_e'(op);
    req.data = data;
    pick_stall(stall);
    @(negedge clk_i);
    dbg_sel_i = sel;
    drive_dmi(sel, 1'b1, req);
    dbg_at_accept = debug_req_o;
    exp_expired   = (cycles_q >= `HC_DBG_HOLDOFF);
    wait_cnt = 0;
    @(negedge clk_i);
    // Response valid rising marks the accepting edge
    while (!sel_resp_valid()) begin
      check_other_quiet();
      dbg_at_accept = debug_req_o;
      exp_expired   = (cycles_q >= `HC_DBG_HOLDOFF);
      wait_cnt++;
      if (wait_cnt > Timeout) begin
        report_error("debug request was never answered");
      end
      @(negedge clk_i);
    end
    drive_dmi(sel, 1'b0, '0);
    rsp = resp_o;
    for (int i = 0; i < int'(stall); i++) begin
      check_other_quiet();
      assert (sel_resp_valid() && resp_o == rsp)
        else report_mismatch("response changed while held by back-pressure");
      assert (!sel_req_ready()) else report_mismatch("request ready high with response pending");
      @(negedge clk_i);
    end
    set_resp_ready(sel, 1'b1);
    @(negedge clk_i);
    set_resp_ready(sel, 1'b0);
    check_other_quiet();
    assert (!sel_resp_valid()) else report_mismatch("response valid stayed high after take");
  endtask

  task automatic run_dmi(input stim_t s);
    dmi_pkg::dmi_resp_t rsp;
    logic [1:0]         exp_resp;
    dmi_xfer(s.sel, s.addr[6:0], s.op, s.data, rsp);
    exp_resp = s.exp_err ? 2'(dmi_pkg::DMI_FAILED) : 2'(dmi_pkg::DMI_SUCCESS);
    assert (rsp.data == s.exp_data)
      else report_mismatch($sformatf("DMI data %h, expected %h", rsp.data, s.exp_data));
    assert (rsp.resp == exp_resp)
      else report_mismatch($sformatf("DMI resp %0d, expected %0d at address %h",
                                     rsp.resp, exp_resp, s.addr));
  endtask

  task automatic check_holdoff();
    dmi_pkg::dmi_resp_t rsp;
    int unsigned        polls;
    logic               expired;
    dmi_xfer(1'b0, `HC_DMI_DMCONTROL, OpWrite, 32'h1, rsp);
    expired = 1'b0;
    polls   = 0;
    while (!expired) begin
      dmi_xfer(1'b0, `HC_DMI_DMSTATUS, OpRead, 32'h0, rsp);
      expired = rsp.data[0];
      assert (expired == exp_expired)
        else report_mismatch($sformatf("dmstatus bit 0 is %b, expected %b",
                                       expired, exp_expired));
      assert (dbg_at_accept == exp_expired)
        else report_mismatch("debug_req_o does not follow the hold-off window");
      polls++;
      if (polls > Timeout) begin
        report_error("hold-off never expired in dmstatus");
      end
    end
    dmi_xfer(1'b0, `HC_DMI_DMCONTROL, OpWrite, 32'h0, rsp);
    assert (!debug_req_o) else report_mismatch("debug_req_o high after haltreq cleared");
  endtask

  initial begin
    clk_i           = 1'b0;
    ndmreset_n      = 1'b0;
    dbg_sel_i       = 1'b0;
    a_req_valid_i   = 1'b0;
    b_req_valid_i   = 1'b0;
    a_req_i         = '0;
    b_req_i         = '0;
    a_resp_ready_i  = 1'b0;
    b_resp_ready_i  = 1'b0;
    mem_req_valid_i = 1'b0;
    mem_req_i       = '0;
    lfsr_q          = 8'd63;
    pend            = 1'b0;
    pend_read       = 1'b0;
    pend_err        = 1'b0;
    pend_data       = '0;
    dbg_at_accept   = 1'b0;
    exp_expired     = 1'b0;
    for (int i = 0; i < `HC_RAM_WORDS * `HC_BE_W; i++) begin
      ram_model[i] = 8'h00;
    end
    repeat (16) @(negedge clk_i);
    ndmreset_n = 1'b1;
    assert (a_req_ready_o && !a_resp_valid_o && !b_resp_valid_o && !debug_req_o &&
            !mem_rsp_valid_o)
      else report_mismatch("outputs not idle after reset");

    check_holdoff();
    for (int i = 0; i < int'(NumStim); i++) begin
      if (stim[i].is_dmi) begin
        mem_flush();
        run_dmi(stim[i]);
      end else begin
        mem_issue(stim[i]);
      end
    end
    mem_flush();
    mem_flush();
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== hw/boot_rom.sv ====
`timescale 1ns/100ps
`include "harness_config.svh"

module boot_rom (
  input  logic                             clk_i,
  input  logic                             req_i,
  input  logic [$clog2(`HC_ROM_WORDS)-1:0] addr_i,
  output logic [`HC_DATA_W-1:0]            rdata_o
);

  typedef logic [`HC_ROM_WORDS-1:0][`HC_DATA_W-1:0] rom_t;

  // Tag in the upper half, word index in the lower half
  function automatic rom_t rom_init();
    rom_t rom;
    for (int unsigned i = 0; i < `HC_ROM_WORDS; i++) begin
      rom[i] = {16'hB007, 16'(i)};
    end
    return rom;
  endfunction

  localparam rom_t RomContents = rom_init();

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= RomContents[addr_i];
    end
  end

endmodule

// ==== hw/dm_regs.sv ====
`timescale 1ns/100ps
`include "harness_config.svh"

module dm_regs (
  input  logic               clk_i,
  input  logic               ndmreset_n,
  input  logic               req_valid_i,
  input  dmi_pkg::dmi_req_t  req_i,
  output logic               req_ready_o,
  output logic               resp_valid_o,
  output dmi_pkg::dmi_resp_t resp_o,
  input  logic               resp_ready_i,
  output logic               debug_req_o
);

  localparam logic [`HC_DMI_ADDR_W-1:0] AddrData0     = `HC_DMI_DATA0;
  localparam logic [`HC_DMI_ADDR_W-1:0] AddrDmcontrol = `HC_DMI_DMCONTROL;
  localparam logic [`HC_DMI_ADDR_W-1:0] AddrDmstatus  = `HC_DMI_DMSTATUS;
  localparam int unsigned CntW = $clog2(`HC_DBG_HOLDOFF + 1);

  logic [31:0]        data0_q;
  logic               haltreq_q;
  logic               resp_valid_q;
  dmi_pkg::dmi_resp_t resp_d;
  dmi_pkg::dmi_resp_t resp_q;
  logic [CntW-1:0]    holdoff_q;
  logic               holdoff_done;
  logic               req_fire;
  logic               wr_data0;
  logic               wr_haltreq;

  // One transaction at a time
  assign req_ready_o  = !resp_valid_q;
  assign req_fire     = req_valid_i && req_ready_o;
  assign holdoff_done = (holdoff_q == '0);

  // ------------------------------
  // Register decode
  // ------------------------------
  always_comb begin
    resp_d.data = '0;
    resp_d.resp = dmi_pkg::DMI_FAILED;
    wr_data0    = 1'b0;
    wr_haltreq  = 1'b0;
    case (req_i.op)
      dmi_pkg::DMI_READ: begin
        resp_d.resp = dmi_pkg::DMI_SUCCESS;
        case (req_i.addr)
          AddrData0:     resp_d.data = data0_q;
          AddrDmcontrol: resp_d.data = 32'(haltreq_q);
          AddrDmstatus:  resp_d.data = 32'(holdoff_done);
          default:       resp_d.resp = dmi_pkg::DMI_FAILED;
        endcase
      end
      dmi_pkg::DMI_WRITE: begin
        resp_d.resp = dmi_pkg::DMI_SUCCESS;
        case (req_i.addr)
          AddrData0:     wr_data0 = 1'b1;
          AddrDmcontrol: wr_haltreq = 1'b1;
          AddrDmstatus:  resp_d.resp = dmi_pkg::DMI_SUCCESS;
          default:       resp_d.resp = dmi_pkg::DMI_FAILED;
        endcase
      end
      default: resp_d.resp = dmi_pkg::DMI_FAILED;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      data0_q      <= '0;
      haltreq_q    <= 1'b0;
      resp_valid_q <= 1'b0;
      holdoff_q    <= CntW'(`HC_DBG_HOLDOFF);
    end else begin
      if (!holdoff_done) begin
        holdoff_q <= holdoff_q - 1'b1;
      end
      if (req_fire) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
      if (req_fire && wr_data0) begin
        data0_q <= req_i.data;
      end
      if (req_fire && wr_haltreq) begin
        haltreq_q <= req_i.data[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q <= resp_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

  // Halt request masked until the hold-off window has passed
  assign debug_req_o = haltreq_q && holdoff_done;

  resp_hold_a : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// ==== hw/dmi_pkg.sv ====
package dmi_pkg;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2
  } dmi_op_e;

  // Same codes as the DTM response field
  typedef enum logic [1:0] {
    DMI_SUCCESS = 2'h0,
    DMI_FAILED  = 2'h2
  } dmi_resp_e;

  typedef struct packed {
    logic [6:0]  addr;
    dmi_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dmi_resp_e   resp;
  } dmi_resp_t;

endpackage

// ==== hw/dmi_source_mux.sv ====
`timescale 1ns/100ps

module dmi_source_mux (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  logic                dbg_sel_i,
  input  logic                a_req_valid_i,
  input  logic                b_req_valid_i,
  input  dmi_pkg::dmi_req_t   a_req_i,
  input  dmi_pkg::dmi_req_t   b_req_i,
  input  logic                a_resp_ready_i,
  input  logic                b_resp_ready_i,
  output logic                a_req_ready_o,
  output logic                b_req_ready_o,
  output logic                a_resp_valid_o,
  output logic                b_resp_valid_o,
  output dmi_pkg::dmi_resp_t  resp_o,
  output logic                dm_req_valid_o,
  output dmi_pkg::dmi_req_t   dm_req_o,
  output logic                dm_resp_ready_o,
  input  logic                dm_req_ready_i,
  input  logic                dm_resp_valid_i,
  input  dmi_pkg::dmi_resp_t  dm_resp_i
);

  // Towards the register block
  assign dm_req_valid_o  = dbg_sel_i ? b_req_valid_i  : a_req_valid_i;
  assign dm_req_o        = dbg_sel_i ? b_req_i        : a_req_i;
  assign dm_resp_ready_o = dbg_sel_i ? b_resp_ready_i : a_resp_ready_i;

  // Only the selected source sees the handshake
  assign a_req_ready_o  = !dbg_sel_i && dm_req_ready_i;
  assign b_req_ready_o  = dbg_sel_i && dm_req_ready_i;
  assign a_resp_valid_o = !dbg_sel_i && dm_resp_valid_i;
  assign b_resp_valid_o = dbg_sel_i && dm_resp_valid_i;

  // Payload is shared, qualified by the valids
  assign resp_o = dm_resp_i;

  // Select only moves between transactions
  sel_stable_a : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (dm_req_valid_o || dm_resp_valid_i) |=> $stable(dbg_sel_i));

endmodule

// ==== hw/harness_config.svh ====
`ifndef HARNESS_CONFIG_SVH
`define HARNESS_CONFIG_SVH

// Memory bus widths
`define HC_ADDR_W 32
`define HC_DATA_W 32
`define HC_BE_W   (`HC_DATA_W / 8)

// Address map
`define HC_ROM_BASE  32'h0001_0000
`define HC_ROM_WORDS 64
`define HC_RAM_BASE  32'h8000_0000
`define HC_RAM_WORDS 256

// Debug link
`define HC_DMI_ADDR_W    7
`define HC_DBG_HOLDOFF   20
`define HC_DMI_DATA0     7'h04
`define HC_DMI_DMCONTROL 7'h10
`define HC_DMI_DMSTATUS  7'h11

`endif

// ==== hw/harness_top.sv ====
`timescale 1ns/100ps
`include "harness_config.svh"

module harness_top (
  input  logic               clk_i,
  input  logic               ndmreset_n,
  input  logic               dbg_sel_i,
  input  logic               a_req_valid_i,
  input  logic               b_req_valid_i,
  input  dmi_pkg::dmi_req_t  a_req_i,
  input  dmi_pkg::dmi_req_t  b_req_i,
  input  logic               a_resp_ready_i,
  input  logic               b_resp_ready_i,
  output logic               a_req_ready_o,
  output logic               b_req_ready_o,
  output logic               a_resp_valid_o,
  output logic               b_resp_valid_o,
  output dmi_pkg::dmi_resp_t resp_o,
  input  logic               mem_req_valid_i,
  input  mem_pkg::mem_req_t  mem_req_i,
  output logic               mem_rsp_valid_o,
  output mem_pkg::mem_rsp_t  mem_rsp_o,
  output logic               debug_req_o
);

  logic                             dm_req_valid;
  dmi_pkg::dmi_req_t                dm_req;
  logic                             dm_resp_ready;
  logic                             dm_req_ready;
  logic                             dm_resp_valid;
  dmi_pkg::dmi_resp_t               dm_resp;

  logic                             rom_req;
  logic [$clog2(`HC_ROM_WORDS)-1:0] rom_addr;
  logic [`HC_DATA_W-1:0]            rom_rdata;
  logic                             ram_req;
  logic                             ram_we;
  logic [$clog2(`HC_RAM_WORDS)-1:0] ram_addr;
  logic [`HC_BE_W-1:0]              ram_be;
  logic [`HC_DATA_W-1:0]            ram_wdata;
  logic [`HC_DATA_W-1:0]            ram_rdata;

  // ------------------------------
  // Debug
  // ------------------------------
  dmi_source_mux i_dmi_source_mux (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .dbg_sel_i       ( dbg_sel_i       ),
    .a_req_valid_i   ( a_req_valid_i   ),
    .b_req_valid_i   ( b_req_valid_i   ),
    .a_req_i         ( a_req_i         ),
    .b_req_i         ( b_req_i         ),
    .a_resp_ready_i  ( a_resp_ready_i  ),
    .b_resp_ready_i  ( b_resp_ready_i  ),
    .a_req_ready_o   ( a_req_ready_o   ),
    .b_req_ready_o   ( b_req_ready_o   ),
    .a_resp_valid_o  ( a_resp_valid_o  ),
    .b_resp_valid_o  ( b_resp_valid_o  ),
    .resp_o          ( resp_o          ),
    .dm_req_valid_o  ( dm_req_valid    ),
    .dm_req_o        ( dm_req          ),
    .dm_resp_ready_o ( dm_resp_ready   ),
    .dm_req_ready_i  ( dm_req_ready    ),
    .dm_resp_valid_i ( dm_resp_valid   ),
    .dm_resp_i       ( dm_resp         )
  );

  dm_regs i_dm_regs (
    .clk_i        ( clk_i         ),
    .ndmreset_n   ( ndmreset_n    ),
    .req_valid_i  ( dm_req_valid  ),
    .req_i        ( dm_req        ),
    .req_ready_o  ( dm_req_ready  ),
    .resp_valid_o ( dm_resp_valid ),
    .resp_o       ( dm_resp       ),
    .resp_ready_i ( dm_resp_ready ),
    .debug_req_o  ( debug_req_o   )
  );

  // ------------------------------
  // Memory
  // ------------------------------
  mem_router i_mem_router (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .mem_req_valid_i ( mem_req_valid_i ),
    .mem_req_i       ( mem_req_i       ),
    .mem_rsp_valid_o ( mem_rsp_valid_o ),
    .mem_rsp_o       ( mem_rsp_o       ),
    .rom_req_o       ( rom_req         ),
    .rom_addr_o      ( rom_addr        ),
    .rom_rdata_i     ( rom_rdata       ),
    .ram_req_o       ( ram_req         ),
    .ram_we_o        ( ram_we          ),
    .ram_addr_o      ( ram_addr        ),
    .ram_be_o        ( ram_be          ),
    .ram_wdata_o     ( ram_wdata       ),
    .ram_rdata_i     ( ram_rdata       )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

  sram_be i_sram_be (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( ram_req    ),
    .we_i       ( ram_we     ),
    .addr_i     ( ram_addr   ),
    .be_i       ( ram_be     ),
    .wdata_i    ( ram_wdata  ),
    .rdata_o    ( ram_rdata  )
  );

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

  // One-cycle strobe request, no back-pressure
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    REGION_NONE = 2'h0,
    REGION_ROM  = 2'h1,
    REGION_RAM  = 2'h2
  } region_e;

endpackage

// ==== hw/mem_router.sv ====
`timescale 1ns/100ps
`include "harness_config.svh"

module mem_router (
  input  logic                                clk_i,
  input  logic                                ndmreset_n,
  input  logic                                mem_req_valid_i,
  input  mem_pkg::mem_req_t                   mem_req_i,
  output logic                                mem_rsp_valid_o,
  output mem_pkg::mem_rsp_t                   mem_rsp_o,
  output logic                                rom_req_o,
  output logic [$clog2(`HC_ROM_WORDS)-1:0]    rom_addr_o,
  input  logic [`HC_DATA_W-1:0]               rom_rdata_i,
  output logic                                ram_req_o,
  output logic                                ram_we_o,
  output logic [$clog2(`HC_RAM_WORDS)-1:0]    ram_addr_o,
  output logic [`HC_BE_W-1:0]                 ram_be_o,
  output logic [`HC_DATA_W-1:0]               ram_wdata_o,
  input  logic [`HC_DATA_W-1:0]               ram_rdata_i
);

  localparam int unsigned OffW    = $clog2(`HC_BE_W);
  localparam int unsigned RomIdxW = $clog2(`HC_ROM_WORDS);
  localparam int unsigned RamIdxW = $clog2(`HC_RAM_WORDS);
  localparam logic [`HC_ADDR_W-1:0] RomBase = `HC_ROM_BASE;
  localparam logic [`HC_ADDR_W-1:0] RomEnd  = `HC_ROM_BASE + `HC_ROM_WORDS * `HC_BE_W;
  localparam logic [`HC_ADDR_W-1:0] RamBase = `HC_RAM_BASE;
  localparam logic [`HC_ADDR_W-1:0] RamEnd  = `HC_RAM_BASE + `HC_RAM_WORDS * `HC_BE_W;

  mem_pkg::region_e region;
  mem_pkg::region_e rd_region_q;
  logic             req_err;
  logic             err_q;
  logic             rsp_valid_q;

  always_comb begin
    region = mem_pkg::REGION_NONE;
    if (mem_req_i.addr >= RomBase && mem_req_i.addr < RomEnd) begin
      region = mem_pkg::REGION_ROM;
    end else if (mem_req_i.addr >= RamBase && mem_req_i.addr < RamEnd) begin
      region = mem_pkg::REGION_RAM;
    end
  end

  // Unmapped, or a write to ROM
  assign req_err = (region == mem_pkg::REGION_NONE) ||
                   (region == mem_pkg::REGION_ROM && mem_req_i.we);

  assign rom_req_o   = mem_req_valid_i && (region == mem_pkg::REGION_ROM) && !mem_req_i.we;
  assign rom_addr_o  = mem_req_i.addr[OffW +: RomIdxW];
  assign ram_req_o   = mem_req_valid_i && (region == mem_pkg::REGION_RAM);
  assign ram_we_o    = mem_req_i.we;
  assign ram_addr_o  = mem_req_i.addr[OffW +: RamIdxW];
  assign ram_be_o    = mem_req_i.be;
  assign ram_wdata_o = mem_req_i.wdata;

  // ------------------------------
  // Response stage
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_q <= 1'b0;
      err_q       <= 1'b0;
      rd_region_q <= mem_pkg::REGION_NONE;
    end else begin
      rsp_valid_q <= mem_req_valid_i;
      err_q       <= mem_req_valid_i && req_err;
      // Only reads return data
      rd_region_q <= (mem_req_valid_i && !mem_req_i.we) ? region : mem_pkg::REGION_NONE;
    end
  end

  assign mem_rsp_valid_o = rsp_valid_q;

  always_comb begin
    mem_rsp_o.err = err_q;
    case (rd_region_q)
      mem_pkg::REGION_ROM: mem_rsp_o.rdata = rom_rdata_i;
      mem_pkg::REGION_RAM: mem_rsp_o.rdata = ram_rdata_i;
      default:             mem_rsp_o.rdata = '0;
    endcase
  end

  // Error responses carry no data
  err_no_data_a : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    mem_rsp_valid_o && mem_rsp_o.err |-> mem_rsp_o.rdata == '0);

endmodule

// ==== hw/sram_be.sv ====
`timescale 1ns/100ps
`include "harness_config.svh"

module sram_be (
  input  logic                             clk_i,
  input  logic                             ndmreset_n,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [$clog2(`HC_RAM_WORDS)-1:0] addr_i,
  input  logic [`HC_BE_W-1:0]              be_i,
  input  logic [`HC_DATA_W-1:0]            wdata_i,
  output logic [`HC_DATA_W-1:0]            rdata_o
);

  logic [`HC_DATA_W-1:0] mem_q [`HC_RAM_WORDS];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      for (int unsigned i = 0; i < `HC_RAM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        // Byte lanes
        for (int unsigned b = 0; b < `HC_BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/dmi_pkg.sv
hw/mem_pkg.sv
hw/dmi_source_mux.sv
hw/dm_regs.sv
hw/mem_router.sv
hw/boot_rom.sv
hw/sram_be.sv
hw/harness_top.sv
dv/harness_tb.sv
